// ==== tage_top.f ====
hw/tage_pkg.sv
hw/tage_hash.sv
hw/tage_bank.sv
hw/tage_base.sv
hw/tage_update.sv
hw/tage_top.sv
tb/tage_checker.sv
tb/tage_tb.sv

// ==== Makefile ====
TOP := tage_tb

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tage_top.f
	./obj_dir/V$(TOP) > sim.log
	@cat sim.log
	@! grep -q '\*\*\* FAILED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tage_tb.sv ====
`timescale 1ns/1ps

module tage_tb import tage_pkg::*; ();

	typedef enum logic [1:0] {
		op_lookup,
		op_update,
		op_stall
	} op_e;

	localparam logic [31:0] pc_a = 32'h0000_1000;
	localparam logic [31:0] pc_b = 32'h0000_1004;
	localparam logic [63:0] gh_a = 64'h0123_4567_89ab_cdef;
	localparam logic [63:0] gh_b = 64'h0123_4567_89ab_cd00;
	localparam int reset_cycles = 16;

	logic                  clk;
	logic                  arst_n;
	logic                  stall;
	logic [31:0]           pc;
	logic [63:0]           ghist;
	logic                  update;
	logic [31:0]           upd_pc;
	logic [63:0]           upd_ghist;
	br_type_e              upd_type;
	logic                  upd_taken;
	logic                  upd_pred;
	logic [bank_count-1:0] upd_provider;
	ctr_t [bank_count-1:0] upd_ctr;
	u_t [bank_count-1:0]   upd_u;
	base_ctr_t             upd_base_ctr;
	logic                  pred_valid;
	logic                  pred;
	logic                  alt_pred;
	logic [bank_count-1:0] provider;
	ctr_t [bank_count-1:0] bank_ctr;
	u_t [bank_count-1:0]   bank_u;
	base_ctr_t             base_ctr;

	// expected values of the current lookup row
	logic                  exp_pred;
	logic                  exp_alt;
	logic [bank_count-1:0] exp_provider;
	base_ctr_t             exp_base;
	ctr_t                  exp_ctr;
	u_t                    exp_u;

	// metadata kept from the last lookup, fed back on update
	logic                  m_pred;
	logic [bank_count-1:0] m_provider;
	ctr_t [bank_count-1:0] m_ctr;
	u_t [bank_count-1:0]   m_u;
	base_ctr_t             m_base;

	op_e                   row_op [$];
	logic [31:0]           row_pc [$];
	logic [63:0]           row_ghist [$];
	br_type_e              row_type [$];
	logic                  row_taken [$];
	logic                  row_pred [$];
	logic                  row_alt [$];
	logic [bank_count-1:0] row_prov [$];
	base_ctr_t             row_base [$];
	ctr_t                  row_ctr [$];
	u_t                    row_u [$];

	int row_id;
	int checks;
	int errors;
	int seq_errors;

	tage_top i_tage_top (
		.clk(clk), .arst_n(arst_n), .stall(stall), .pc(pc), .ghist(ghist),
		.update(update), .upd_pc(upd_pc), .upd_ghist(upd_ghist), .upd_type(upd_type),
		.upd_taken(upd_taken), .upd_pred(upd_pred), .upd_provider(upd_provider),
		.upd_ctr(upd_ctr), .upd_u(upd_u), .upd_base_ctr(upd_base_ctr),
		.pred_valid(pred_valid), .pred(pred), .alt_pred(alt_pred), .provider(provider),
		.bank_ctr(bank_ctr), .bank_u(bank_u), .base_ctr(base_ctr)
	);

	tage_checker i_checker (
		.clk(clk), .arst_n(arst_n), .stall(stall), .row_id(row_id),
		.pred_valid(pred_valid), .pred(pred), .alt_pred(alt_pred), .provider(provider),
		.bank_ctr(bank_ctr), .bank_u(bank_u), .base_ctr(base_ctr),
		.exp_pred(exp_pred), .exp_alt(exp_alt), .exp_provider(exp_provider),
		.exp_base(exp_base), .exp_ctr(exp_ctr), .exp_u(exp_u),
		.checks(checks), .errors(errors)
	);

	always #5 clk = ~clk;

	task automatic add_row(input op_e op, input logic [31:0] a, input logic [63:0] g,
			input br_type_e t, input logic tk, input logic p, input logic alt,
			input logic [bank_count-1:0] prov, input base_ctr_t b, input ctr_t c, input u_t u);
		row_op.push_back(op);
		row_pc.push_back(a);
		row_ghist.push_back(g);
		row_type.push_back(t);
		row_taken.push_back(tk);
		row_pred.push_back(p);
		row_alt.push_back(alt);
		row_prov.push_back(prov);
		row_base.push_back(b);
		row_ctr.push_back(c);
		row_u.push_back(u);
	endtask

	task automatic build_table();
		// op, pc, ghist, type, taken | pred, alt, provider, base, provider ctr, provider u
		add_row(op_stall, pc_b, gh_b, br_cond, 0, 0, 0, 4'b0000, 2'd1, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 0, 0, 4'b0000, 2'd1, 3'd0, 2'd0);
		add_row(op_update, pc_a, gh_a, br_cond, 1, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 1, 1, 4'b0001, 2'd2, 3'd4, 2'd0);
		add_row(op_update, pc_a, gh_a, br_cond, 1, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 1, 1, 4'b0001, 2'd3, 3'd5, 2'd0);
		add_row(op_update, pc_a, gh_a, br_cond, 0, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 0, 1, 4'b0010, 2'd2, 3'd3, 2'd0);
		add_row(op_update, pc_a, gh_a, br_jump, 1, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 0, 1, 4'b0010, 2'd2, 3'd3, 2'd0);
		// alternate ghist keeps the shared base counter swinging around 2
		add_row(op_update, pc_a, gh_a, br_cond, 0, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_b, br_cond, 0, 0, 0, 4'b0000, 2'd1, 3'd0, 2'd0);
		add_row(op_update, pc_a, gh_b, br_cond, 1, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 0, 1, 4'b0010, 2'd2, 3'd2, 2'd1);
		add_row(op_update, pc_a, gh_a, br_cond, 0, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_b, br_cond, 0, 1, 0, 4'b0001, 2'd1, 3'd4, 2'd0);
		add_row(op_update, pc_a, gh_b, br_cond, 1, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 0, 1, 4'b0010, 2'd2, 3'd1, 2'd2);
		add_row(op_update, pc_a, gh_a, br_cond, 0, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_b, br_cond, 0, 1, 0, 4'b0001, 2'd1, 3'd5, 2'd1);
		add_row(op_update, pc_a, gh_b, br_cond, 1, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 0, 1, 4'b0010, 2'd2, 3'd0, 2'd3);
		add_row(op_update, pc_a, gh_a, br_cond, 0, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_b, br_cond, 0, 1, 0, 4'b0001, 2'd1, 3'd6, 2'd2);
		add_row(op_update, pc_a, gh_b, br_cond, 1, 0, 0, 4'b0000, 2'd0, 3'd0, 2'd0);
		add_row(op_lookup, pc_a, gh_a, br_cond, 0, 0, 1, 4'b0010, 2'd2, 3'd0, 2'd3);
		add_row(op_lookup, pc_b, gh_a, br_cond, 0, 0, 0, 4'b0000, 2'd1, 3'd0, 2'd0);
	endtask

	task automatic issue_lookup(input int r);
		int waited;
		waited = 0;
		@(negedge clk);
		row_id = r;
		stall = 1'b0;
		pc = row_pc[r];
		ghist = row_ghist[r];
		exp_pred = row_pred[r];
		exp_alt = row_alt[r];
		exp_provider = row_prov[r];
		exp_base = row_base[r];
		exp_ctr = row_ctr[r];
		exp_u = row_u[r];
		@(negedge clk);
		stall = 1'b1;
		while (!pred_valid && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (!pred_valid) begin
			seq_errors++;
			$display("row %0d: pred_valid never came after the lookup", r);
		end
		m_pred = pred;
		m_provider = provider;
		m_ctr = bank_ctr;
		m_u = bank_u;
		m_base = base_ctr;
	endtask

	task automatic apply_update(input int r);
		@(negedge clk);
		row_id = r;
		update = 1'b1;
		upd_pc = row_pc[r];
		upd_ghist = row_ghist[r];
		upd_type = row_type[r];
		upd_taken = row_taken[r];
		upd_pred = m_pred;
		upd_provider = m_provider;
		upd_ctr = m_ctr;
		upd_u = m_u;
		upd_base_ctr = m_base;
		@(negedge clk);
		update = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic hold_stall(input int r);
		@(negedge clk);
		row_id = r;
		stall = 1'b1;
		pc = row_pc[r];
		ghist = row_ghist[r];
		repeat (3) @(negedge clk);
	endtask

	// watchdog, five cycles per row on top of reset
	initial begin
		#1;
		repeat (row_op.size() * 5 + reset_cycles + 4) @(posedge clk);
		$display("timeout: the table did not finish in time, checker errors %0d", errors);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int total;
		clk = 1'b0;
		arst_n = 1'b0;
		stall = 1'b1;
		pc = '0;
		ghist = '0;
		update = 1'b0;
		upd_pc = '0;
		upd_ghist = '0;
		upd_type = br_cond;
		upd_taken = 1'b0;
		upd_pred = 1'b0;
		upd_provider = '0;
		upd_ctr = '0;
		upd_u = '0;
		upd_base_ctr = '0;
		exp_pred = 1'b0;
		exp_alt = 1'b0;
		exp_provider = '0;
		exp_base = '0;
		exp_ctr = '0;
		exp_u = '0;
		row_id = 0;
		seq_errors = 0;
		build_table();
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int r = 0; r < row_op.size(); r++) begin
			case (row_op[r])
				op_lookup: issue_lookup(r);
				op_update: apply_update(r);
				default: hold_stall(r);
			endcase
		end
		repeat (2) @(negedge clk);
		total = errors + seq_errors;
		$display("checks %0d, checker errors %0d, sequence errors %0d",
			checks, errors, seq_errors);
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== tb/tage_checker.sv ====
`timescale 1ns/1ps

module tage_checker import tage_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  stall,
	input  int                    row_id,
	input  logic                  pred_valid,
	input  logic                  pred,
	input  logic                  alt_pred,
	input  logic [bank_count-1:0] provider,
	input  ctr_t [bank_count-1:0] bank_ctr,
	input  u_t [bank_count-1:0]   bank_u,
	input  base_ctr_t             base_ctr,
	input  logic                  exp_pred,
	input  logic                  exp_alt,
	input  logic [bank_count-1:0] exp_provider,
	input  base_ctr_t             exp_base,
	input  ctr_t                  exp_ctr,
	input  u_t                    exp_u,
	output int                    checks,
	output int                    errors
);
	logic stall_q;
	logic valid_q;
	int   idx;

	task automatic compare_field(input string name, input logic [7:0] got,
			input logic [7:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Fail row %0d %s: got 0x%h expected 0x%h", row_id, name, got, want);
		end
	endtask

	function automatic int onehot_index(input logic [bank_count-1:0] v);
		int k;
		k = 0;
		for (int j = 0; j < bank_count; j++) begin
			if (v[j]) begin
				k = j;
			end
		end
		return k;
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stall_q = 1'b1;
			valid_q = 1'b0;
		end else begin
			// pred_valid follows the stall level one cycle late
			compare_field("pred_valid", pred_valid, !stall_q);
			if (pred_valid && !valid_q) begin
				compare_field("pred", pred, exp_pred);
				compare_field("alt_pred", alt_pred, exp_alt);
				compare_field("provider", provider, exp_provider);
				compare_field("base_ctr", base_ctr, exp_base);
				// counters only mean something for a hitting bank
				if (|exp_provider) begin
					idx = onehot_index(exp_provider);
					compare_field("bank_ctr", bank_ctr[idx], exp_ctr);
					compare_field("bank_u", bank_u[idx], exp_u);
				end
			end
			valid_q = pred_valid;
			stall_q = stall;
		end
	end

endmodule

// ==== hw/tage_top.sv ====
`timescale 1ns/1ps

module tage_top import tage_pkg::*; #(
	parameter int set_width = 7,
	parameter int tag_width = 8,
	parameter int base_width = 9
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  stall,
	input  logic [31:0]           pc,
	input  logic [63:0]           ghist,
	input  logic                  update,
	input  logic [31:0]           upd_pc,
	input  logic [63:0]           upd_ghist,
	input  br_type_e              upd_type,
	input  logic                  upd_taken,
	input  logic                  upd_pred,
	input  logic [bank_count-1:0] upd_provider,
	input  ctr_t [bank_count-1:0] upd_ctr,
	input  u_t [bank_count-1:0]   upd_u,
	input  base_ctr_t             upd_base_ctr,
	output logic                  pred_valid,
	output logic                  pred,
	output logic                  alt_pred,
	output logic [bank_count-1:0] provider,
	output ctr_t [bank_count-1:0] bank_ctr,
	output u_t [bank_count-1:0]   bank_u,
	output base_ctr_t             base_ctr
);
	logic [set_width-1:0]  lookup_index [bank_count];
	logic [tag_width-1:0]  lookup_tag [bank_count];
	logic [set_width-1:0]  update_index [bank_count];
	logic [tag_width-1:0]  update_tag [bank_count];
	logic [bank_count-1:0] hit;
	logic [bank_count-1:0] bank_taken;
	logic [bank_count-1:0] bank_we;
	logic [bank_count-1:0] bank_u_we;
	logic [bank_count-1:0] bank_alloc;
	ctr_t [bank_count-1:0] bank_new_ctr;
	u_t [bank_count-1:0]   bank_new_u;
	logic                  base_we;
	base_ctr_t             base_new_ctr;

	for (genvar b = 0; b < bank_count; b++) begin : g_bank
		tage_hash #(
			.set_width(set_width),
			.tag_width(tag_width),
			.hist_bits(hist_len[b])
		) i_lookup_hash (
			.pc(pc),
			.ghist(ghist),
			.index(lookup_index[b]),
			.tag(lookup_tag[b])
		);

		// update side hashes the pc and history saved at lookup
		tage_hash #(
			.set_width(set_width),
			.tag_width(tag_width),
			.hist_bits(hist_len[b])
		) i_update_hash (
			.pc(upd_pc),
			.ghist(upd_ghist),
			.index(update_index[b]),
			.tag(update_tag[b])
		);

		tage_bank #(
			.set_width(set_width),
			.tag_width(tag_width)
		) i_bank (
			.clk(clk),
			.arst_n(arst_n),
			.en(!stall),
			.lookup_index(lookup_index[b]),
			.lookup_tag(lookup_tag[b]),
			.we(bank_we[b]),
			.u_we(bank_u_we[b]),
			.alloc(bank_alloc[b]),
			.update_index(update_index[b]),
			.update_tag(update_tag[b]),
			.new_ctr(bank_new_ctr[b]),
			.new_u(bank_new_u[b]),
			.hit(hit[b]),
			.ctr(bank_ctr[b]),
			.u(bank_u[b])
		);

		assign bank_taken[b] = bank_ctr[b][2];
	end

	tage_base #(
		.base_width(base_width)
	) i_base (
		.clk(clk),
		.arst_n(arst_n),
		.en(!stall),
		.lookup_pc(pc),
		.we(base_we),
		.update_pc(upd_pc),
		.new_ctr(base_new_ctr),
		.ctr(base_ctr)
	);

	tage_update i_update (
		.update(update),
		.upd_type(upd_type),
		.upd_taken(upd_taken),
		.upd_pred(upd_pred),
		.upd_provider(upd_provider),
		.upd_ctr(upd_ctr),
		.upd_u(upd_u),
		.upd_base_ctr(upd_base_ctr),
		.bank_we(bank_we),
		.bank_u_we(bank_u_we),
		.bank_alloc(bank_alloc),
		.bank_new_ctr(bank_new_ctr),
		.bank_new_u(bank_new_u),
		.base_we(base_we),
		.base_new_ctr(base_new_ctr)
	);

	// longest history hit wins
	always_comb begin
		provider = '0;
		for (int b = 0; b < bank_count; b++) begin
			if (hit[b]) begin
				provider = '0;
				provider[b] = 1'b1;
			end
		end
	end

	assign alt_pred = base_ctr[1];
	assign pred = (|provider) ? |(bank_taken & provider) : alt_pred;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pred_valid <= 1'b0;
		end else begin
			pred_valid <= !stall;
		end
	end

endmodule

// ==== hw/tage_update.sv ====
`timescale 1ns/1ps

module tage_update import tage_pkg::*; (
	input  logic                    update,
	input  br_type_e                upd_type,
	input  logic                    upd_taken,
	input  logic                    upd_pred,
	input  logic [bank_count-1:0]   upd_provider,
	input  ctr_t [bank_count-1:0]   upd_ctr,
	input  u_t [bank_count-1:0]     upd_u,
	input  base_ctr_t               upd_base_ctr,
	output logic [bank_count-1:0]   bank_we,
	output logic [bank_count-1:0]   bank_u_we,
	output logic [bank_count-1:0]   bank_alloc,
	output ctr_t [bank_count-1:0]   bank_new_ctr,
	output u_t [bank_count-1:0]     bank_new_u,
	output logic                    base_we,
	output base_ctr_t               base_new_ctr
);
	logic                  train;
	logic                  alt_pred;
	logic                  mispred;
	logic                  use_alt_differs;
	logic                  do_alloc;
	logic                  no_free;
	logic                  seen;
	logic [bank_count-1:0] above;
	logic [bank_count-1:0] free;

	function automatic ctr_t ctr_step(input ctr_t c, input logic up);
		if (up) begin
			return (c == 3'd7) ? c : c + 3'd1;
		end
		return (c == 3'd0) ? c : c - 3'd1;
	endfunction

	function automatic logic [1:0] sat2_step(input logic [1:0] c, input logic up);
		if (up) begin
			return (c == 2'd3) ? c : c + 2'd1;
		end
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	assign train = update && (upd_type == br_cond);
	assign alt_pred = upd_base_ctr[1];
	assign mispred = upd_pred != upd_taken;
	assign use_alt_differs = upd_pred != alt_pred;

	assign base_we = train;
	assign base_new_ctr = sat2_step(upd_base_ctr, upd_taken);

	// banks above the provider, all banks when nothing hit
	always_comb begin
		seen = ~|upd_provider;
		above = '0;
		free = '0;
		for (int j = 0; j < bank_count; j++) begin
			above[j] = seen;
			free[j] = seen && (upd_u[j] == 2'd0);
			if (upd_provider[j]) begin
				seen = 1'b1;
			end
		end
	end

	// top bank as provider has nowhere longer to go
	assign do_alloc = train && mispred && !upd_provider[bank_count-1];
	assign no_free = do_alloc && (free == '0);
	assign bank_alloc = do_alloc ? (free & (~free + 1'b1)) : '0;

	always_comb begin
		for (int j = 0; j < bank_count; j++) begin
			bank_we[j] = train && (upd_provider[j] || bank_alloc[j]);
			if (bank_alloc[j]) begin
				bank_new_ctr[j] = upd_taken ? ctr_weak_taken : ctr_weak_not_taken;
			end else begin
				bank_new_ctr[j] = ctr_step(upd_ctr[j], upd_taken);
			end
			bank_u_we[j] = (train && upd_provider[j] && use_alt_differs) || (no_free && above[j]);
			if (bank_alloc[j]) begin
				bank_new_u[j] = '0;
			end else if (upd_provider[j]) begin
				bank_new_u[j] = sat2_step(upd_u[j], !mispred);
			end else begin
				// aging when no bank could take the entry
				bank_new_u[j] = sat2_step(upd_u[j], 1'b0);
			end
		end
	end

	always_comb begin
		a_alloc_onehot: assert final ($onehot0(bank_alloc));
		a_we_cond_only: assert final (!(|{bank_we, bank_u_we, base_we}) || train);
	end

endmodule

// ==== hw/tage_base.sv ====
`timescale 1ns/1ps

module tage_base import tage_pkg::*; #(
	parameter int base_width = 9
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        en,
	input  logic [31:0] lookup_pc,
	input  logic        we,
	input  logic [31:0] update_pc,
	input  base_ctr_t   new_ctr,
	output base_ctr_t   ctr
);
	localparam int depth = 1 << base_width;

	base_ctr_t             ctr_mem [depth];
	logic [base_width-1:0] lookup_index;
	logic [base_width-1:0] update_index;

	function automatic logic [base_width-1:0] fold_pc(input logic [31:0] a);
		return a[base_width+1:2] ^ a[2*base_width+1:base_width+2];
	endfunction

	assign lookup_index = fold_pc(lookup_pc);
	assign update_index = fold_pc(update_pc);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < depth; i++) begin
				ctr_mem[i] <= base_ctr_reset;
			end
			ctr <= base_ctr_reset;
		end else begin
			if (en) begin
				ctr <= ctr_mem[lookup_index];
			end
			if (we) begin
				ctr_mem[update_index] <= new_ctr;
			end
		end
	end

endmodule

// ==== hw/tage_bank.sv ====
`timescale 1ns/1ps

module tage_bank import tage_pkg::*; #(
	parameter int set_width = 7,
	parameter int tag_width = 8
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 en,
	input  logic [set_width-1:0] lookup_index,
	input  logic [tag_width-1:0] lookup_tag,
	input  logic                 we,
	input  logic                 u_we,
	input  logic                 alloc,
	input  logic [set_width-1:0] update_index,
	input  logic [tag_width-1:0] update_tag,
	input  ctr_t                 new_ctr,
	input  u_t                   new_u,
	output logic                 hit,
	output ctr_t                 ctr,
	output u_t                   u
);
	localparam int depth = 1 << set_width;

	logic [depth-1:0]     valid_q;
	logic [tag_width-1:0] tag_mem [depth];
	ctr_t                 ctr_mem [depth];
	u_t                   u_mem [depth];

	logic                 rd_valid;
	logic [tag_width-1:0] rd_tag;
	logic [tag_width-1:0] lookup_tag_q;
	ctr_t                 rd_ctr;
	u_t                   rd_u;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			rd_valid <= 1'b0;
		end else begin
			if (en) begin
				rd_valid <= valid_q[lookup_index];
			end
			if (we && alloc) begin
				valid_q[update_index] <= 1'b1;
			end
		end
	end

	// read before write, a lookup at the update edge sees old data
	always_ff @(posedge clk) begin
		if (en) begin
			rd_tag <= tag_mem[lookup_index];
			rd_ctr <= ctr_mem[lookup_index];
			rd_u <= u_mem[lookup_index];
			lookup_tag_q <= lookup_tag;
		end
		if (we) begin
			ctr_mem[update_index] <= new_ctr;
		end
		if (we && alloc) begin
			tag_mem[update_index] <= update_tag;
		end
		if (u_we || (we && alloc)) begin
			u_mem[update_index] <= new_u;
		end
	end

	assign hit = rd_valid && (rd_tag == lookup_tag_q);
	// empty slots report zero so they look free for allocation
	assign ctr = rd_valid ? rd_ctr : '0;
	assign u = rd_valid ? rd_u : '0;

	// allocation comes only with a write from the update logic
	a_alloc_has_we: assert property (@(posedge clk) disable iff (!arst_n) alloc |-> we);

endmodule

// ==== hw/tage_hash.sv ====
`timescale 1ns/1ps

module tage_hash #(
	parameter int set_width = 7,
	parameter int tag_width = 8,
	parameter int hist_bits = 8
) (
	input  logic [31:0]          pc,
	input  logic [63:0]          ghist,
	output logic [set_width-1:0] index,
	output logic [tag_width-1:0] tag
);
	logic [29:0]          pc_word;
	logic [29:0]          pc_mix;
	logic [set_width-1:0] fold_i;
	logic [tag_width-1:0] fold_t1;
	logic [tag_width-2:0] fold_t2;

	// fold history into chunks of each width
	always_comb begin
		fold_i = '0;
		fold_t1 = '0;
		fold_t2 = '0;
		for (int i = 0; i < hist_bits; i++) begin
			fold_i[i % set_width] ^= ghist[i];
			fold_t1[i % tag_width] ^= ghist[i];
			fold_t2[i % (tag_width - 1)] ^= ghist[i];
		end
	end

	// instructions are word aligned
	assign pc_word = pc[31:2];
	assign pc_mix = pc_word ^ (pc_word >> set_width);

	assign index = pc_mix[set_width-1:0] ^ fold_i;
	// second fold shifted by one so history bits do not cancel in the tag
	assign tag = pc_mix[set_width +: tag_width] ^ fold_t1 ^ {fold_t2, 1'b0};

endmodule

// ==== hw/tage_pkg.sv ====
package tage_pkg;

	// tagged banks, bank 0 has the shortest history
	localparam int bank_count = 4;

	// global history bits folded into each bank
	localparam int hist_len [bank_count] = '{8, 16, 32, 64};

	// tagged prediction counter, msb is the direction
	typedef logic [2:0] ctr_t;

	// useful counter of a tagged entry
	typedef logic [1:0] u_t;

	// bimodal base counter
	typedef logic [1:0] base_ctr_t;

	// counter values written on allocation
	localparam ctr_t ctr_weak_taken = 3'd4;
	localparam ctr_t ctr_weak_not_taken = 3'd3;

	// base counters come out of reset weak not-taken
	localparam base_ctr_t base_ctr_reset = 2'd1;

	// branch type of a resolved branch, only br_cond trains
	typedef enum logic [1:0] {
		br_cond,
		br_jump,
		br_call,
		br_ret
	} br_type_e;

endpackage
